// File: i2c_master_top.f
+incdir+verilog
verilog/i2c_master_pkg.sv
verilog/i2c_reg_decode.sv
verilog/i2c_byte_engine.sv
verilog/i2c_status_result.sv
verilog/i2c_master_top.sv
tb/i2c_clk_gen.sv
tb/i2c_master_props.sv
tb/i2c_master_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f i2c_master_top.f \
    --top-module i2c_master_tb -o i2c_master_sim

out="$(./obj_dir/i2c_master_sim || true)"
echo "$out"

if echo "$out" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1

// File: tb/i2c_clk_gen.sv
module i2c_clk_gen (
    output logic o_sysclk,
    output logic o_reset_n
);

    initial begin
        o_sysclk = 1'b0;
        forever #50 o_sysclk = ~o_sysclk; // 100 unit period
    end

    initial begin
        o_reset_n = 1'b0;
        repeat (4) @(posedge o_sysclk);
        @(negedge o_sysclk);
        o_reset_n = 1'b1;
    end

endmodule

// File: tb/i2c_master_golden.txt
// op addr data expected, hex; read uses data as mask
// op 0 wr, 1 rd, 2 irq wait, 3 slave tx, 4 slave ack, 5 arb bit, 6-9 checks
1 0c ff 81
1 08 ff 00
8 00 00 01
0 00 5a 00
1 00 ff 5a
0 04 02 00
1 04 ff 02
0 08 04 00
1 08 ff 00
0 08 f0 00
2 00 00 00
1 0c ff a3
4 00 00 00
0 10 a5 00
2 00 00 00
1 0c ff a2
8 00 01 01
6 00 00 a5
3 00 3c 00
0 08 e8 00
1 10 00 00
2 00 00 00
0 0c 00 00
8 00 00 01
1 10 ff 3c
1 0c ff a1
7 00 00 01
0 08 c0 00
2 00 00 00
1 0c ff 83
0 0c 00 00
8 00 00 01
1 0c ff 81
4 00 00 00
5 00 02 00
0 08 f0 00
2 00 00 00
0 10 ff 00
2 00 00 00
1 0c ff 93
9 00 00 00
ff 00 00 00

// File: tb/i2c_master_props.sv
module i2c_master_props (
    input logic                           i_sysclk,
    input logic                           i_reset_n,
    input i2c_master_pkg::i2c_cmd_t       i_cmd,
    input i2c_master_pkg::i2c_rsp_t       i_rsp,
    input logic                           i_busy,
    input logic                           i_scl_low,
    input logic                           i_sda_low,
    input i2c_master_pkg::i2c_bit_state_e i_state
);
    import i2c_master_pkg::*;

    logic start_stop;

    assign start_stop = (i_state == ST_START_A) || (i_state == ST_START_B) ||
                        (i_state == ST_STOP_A) || (i_state == ST_STOP_B);

    go_not_busy: assert property (@(posedge i_sysclk) disable iff (!i_reset_n)
        i_cmd.go |-> !i_busy)
        else $error("command strobe while engine busy");

    // data line moves only under low scl, except start and stop conditions
    sda_stable: assert property (@(posedge i_sysclk) disable iff (!i_reset_n)
        (i_sda_low != $past(i_sda_low)) |-> ($past(i_scl_low) || $past(start_stop)))
        else $error("sda changed while scl high");

    done_pulse: assert property (@(posedge i_sysclk) disable iff (!i_reset_n)
        i_rsp.done |=> !i_rsp.done)
        else $error("done held longer than one cycle");

endmodule

bind i2c_byte_engine i2c_master_props u_props (
    .i_sysclk  (i_sysclk),
    .i_reset_n (i_reset_n),
    .i_cmd     (i_cmd),
    .i_rsp     (o_rsp),
    .i_busy    (o_busy),
    .i_scl_low (o_scl_low),
    .i_sda_low (o_sda_low),
    .i_state   (state)
);

// File: tb/i2c_master_tb.sv
module i2c_master_tb;

    localparam int BIT_CLKS  = 4 * 64; // worst case bit length
    localparam int INT_LIMIT = 40 * BIT_CLKS;

    logic       i_sysclk;
    logic       i_reset_n;
    logic       i_wr_ena;
    logic [4:0] i_wr_addr;
    logic [7:0] i_wr_data;
    logic       i_rd_ena;
    logic [4:0] i_rd_addr;
    logic [7:0] o_rd_data;
    logic       o_read_ready;
    logic       o_write_ready;
    logic       o_interrupt;
    logic       o_scl_low;
    logic       o_sda_low;
    logic       scl;
    logic       sda;

    logic [7:0] gold [0:255];
    int         nsteps;
    int         errors;
    logic       loaded;

    // slave model
    int         cfg_seq;
    int         cfg_seen;
    logic [1:0] cfg_mode;   // 0 idle, 1 receive, 2 transmit
    logic [1:0] mode;
    logic [7:0] tx_byte;
    logic       ack_nak;
    logic [7:0] arb_bit;    // ff when no forced bit
    logic [3:0] cnt;
    logic       seen_rise;
    logic       scl_q;
    logic       sda_q;
    logic [7:0] shift;
    logic [7:0] captured;
    logic       master_ack;
    logic       slave_low;

    i2c_clk_gen u_clk_gen (
        .o_sysclk  (i_sysclk),
        .o_reset_n (i_reset_n)
    );

    i2c_master_top i_i2c_master_top (
        .i_sysclk      (i_sysclk),
        .i_reset_n     (i_reset_n),
        .i_wr_ena      (i_wr_ena),
        .i_wr_addr     (i_wr_addr),
        .i_wr_data     (i_wr_data),
        .i_rd_ena      (i_rd_ena),
        .i_rd_addr     (i_rd_addr),
        .o_rd_data     (o_rd_data),
        .o_read_ready  (o_read_ready),
        .o_write_ready (o_write_ready),
        .o_interrupt   (o_interrupt),
        .i_scl         (scl),
        .i_sda         (sda),
        .o_scl_low     (o_scl_low),
        .o_sda_low     (o_sda_low)
    );

    // wired-and bus with pull-ups
    assign scl = !o_scl_low;
    assign sda = !(o_sda_low || slave_low);

    always_comb begin
        slave_low = 1'b0;
        if (mode == 2'd1) begin
            slave_low = ((cnt == 4'd8) && !ack_nak) || ({4'd0, cnt} == arb_bit);
        end else if (mode == 2'd2) begin
            slave_low = (cnt < 4'd8) && !tx_byte[3'd7 - cnt[2:0]];
        end
    end

    always @(negedge i_sysclk) begin
        if (!i_reset_n) begin
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
            cnt        <= 4'd0;
            seen_rise  <= 1'b0;
            shift      <= 8'h00;
            captured   <= 8'h00;
            master_ack <= 1'b1;
            mode       <= 2'd0;
            cfg_seen   <= 0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (cfg_seen != cfg_seq) begin
                cfg_seen <= cfg_seq;
                mode     <= cfg_mode;
            end
            if (scl_q && scl && sda_q && !sda) begin
                cnt       <= 4'd0; // start condition
                seen_rise <= 1'b0;
            end else if (scl && !scl_q) begin
                seen_rise <= 1'b1;
                if (cnt < 4'd8) begin
                    shift <= {shift[6:0], sda};
                end else if (mode == 2'd2) begin
                    master_ack <= sda;
                end
            end else if (!scl && scl_q && seen_rise) begin
                seen_rise <= 1'b0;
                if (cnt == 4'd8) begin
                    cnt <= 4'd0;
                    if (mode == 2'd1) begin
                        captured <= shift;
                    end
                    if ((mode == 2'd2) && master_ack) begin
                        mode <= 2'd0; // nak ends the transfer
                    end
                end else begin
                    cnt <= cnt + 4'd1;
                end
            end
        end
    end

    function automatic string reg_name(input logic [7:0] addr);
        case (addr[4:2])
            3'd0:    return "rd_data(adr)";
            3'd1:    return "rd_data(fdr)";
            3'd2:    return "rd_data(cr)";
            3'd3:    return "rd_data(sr)";
            default: return "rd_data(dr)";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [7:0] exp,
                               input logic [7:0] act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED time=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        i_wr_ena  = 1'b1;
        i_wr_addr = addr[4:0];
        i_wr_data = data;
        @(negedge i_sysclk);
        i_wr_ena  = 1'b0;
    endtask

    task automatic read_check(input logic [7:0] addr, input logic [7:0] mask,
                              input logic [7:0] exp);
        i_rd_ena  = 1'b1;
        i_rd_addr = addr[4:0];
        @(negedge i_sysclk);
        i_rd_ena  = 1'b0;
        if (!o_read_ready) begin
            errors++;
            $display("CHECK FAILED time=%0t o_read_ready expected=1 actual=0", $time);
        end
        if ((o_rd_data & mask) !== (exp & mask)) begin
            errors++;
            $display("CHECK FAILED time=%0t %s expected=%h actual=%h",
                     $time, reg_name(addr), exp & mask, o_rd_data & mask);
        end
    endtask

    task automatic wait_interrupt();
        int n;
        n = 0;
        while (o_write_ready && (n < 64)) begin
            @(negedge i_sysclk);
            n++;
        end
        if (o_write_ready) begin
            errors++;
            $display("ERROR: time=%0t no bus command was started", $time);
        end else begin
            n = 0;
            while (!o_interrupt && (n < INT_LIMIT)) begin
                @(negedge i_sysclk);
                n++;
            end
            if (!o_interrupt) begin
                errors++;
                $display("ERROR: time=%0t interrupt never arrived after %0d cycles", $time, n);
            end
        end
    endtask

    initial begin
        logic [7:0] op;
        logic [7:0] a;
        logic [7:0] d;
        logic [7:0] e;
        i_wr_ena  = 1'b0;
        i_wr_addr = 5'd0;
        i_wr_data = 8'h00;
        i_rd_ena  = 1'b0;
        i_rd_addr = 5'd0;
        errors    = 0;
        loaded    = 1'b0;
        cfg_seq   = 0;
        cfg_mode  = 2'd0;
        tx_byte   = 8'hff;
        ack_nak   = 1'b0;
        arb_bit   = 8'hff;
        void'($urandom(32'h7a6d_442c));
        $readmemh("tb/i2c_master_golden.txt", gold);
        nsteps = 0;
        while ((nsteps < 64) && (gold[4 * nsteps] != 8'hff)) begin
            nsteps++;
        end
        loaded = 1'b1;
        wait (i_reset_n);
        @(negedge i_sysclk);
        for (int s = 0; s < nsteps; s++) begin
            op = gold[4 * s];
            a  = gold[4 * s + 1];
            d  = gold[4 * s + 2];
            e  = gold[4 * s + 3];
            case (op)
                8'h0: write_reg(a, d);
                8'h1: read_check(a, d, e);
                8'h2: wait_interrupt();
                8'h3: begin
                    tx_byte  = d;
                    arb_bit  = 8'hff;
                    cfg_mode = 2'd2;
                    cfg_seq++;
                end
                8'h4: begin
                    ack_nak  = d[0];
                    arb_bit  = 8'hff;
                    cfg_mode = 2'd1;
                    cfg_seq++;
                end
                8'h5: arb_bit = d;
                8'h6: check_value("captured", e, captured);
                8'h7: check_value("master_ack", e, {7'd0, master_ack});
                8'h8: begin
                    check_value("o_interrupt", d, {7'd0, o_interrupt});
                    check_value("o_write_ready", e, {7'd0, o_write_ready});
                end
                8'h9: begin
                    check_value("o_scl_low", 8'h00, {7'd0, o_scl_low});
                    check_value("o_sda_low", 8'h00, {7'd0, o_sda_low});
                end
                default: begin
                    errors++;
                    $display("ERROR: unknown golden operation %h at step %0d", op, s);
                end
            endcase
            repeat ($urandom_range(3, 0)) @(negedge i_sysclk); // idle gap
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        longint limit;
        wait (loaded);
        limit = longint'(nsteps) * 40 * BIT_CLKS * 100;
        #(limit);
        $display("ERROR: watchdog expired at time %0t, run did not finish", $time);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: verilog/i2c_byte_engine.sv
`include "i2c_master_cfg.svh"

module i2c_byte_engine (
    input  logic                     i_sysclk,
    input  logic                     i_reset_n,
    input  i2c_master_pkg::i2c_cmd_t i_cmd,
    input  logic [7:0]               i_fdr,
    input  logic                     i_scl,
    input  logic                     i_sda,
    output logic                     o_scl_low,
    output logic                     o_sda_low,
    output logic                     o_busy,
    output i2c_master_pkg::i2c_rsp_t o_rsp
);
    import i2c_master_pkg::*;

    i2c_bit_state_e state;
    i2c_cmd_e       op_r;
    logic [6:0]     qtr_cnt;
    logic [6:0]     qtr_len;
    logic [1:0]     qtr;
    logic           tick;
    logic [2:0]     bit_cnt;
    logic [7:0]     shift_r;
    logic           txak_r;
    logic           rx_ack_r;
    logic           al_r;
    logic           scl_low_r;
    logic           sda_low_r;
    logic           start_go;

    assign qtr_len  = `I2C_QTR_CLKS(i_fdr);
    assign tick     = (qtr_cnt >= qtr_len);
    assign start_go = (state == ST_IDLE) && i_cmd.go && (i_cmd.op != CMD_IDLE);

    // quarter-period timer, parked while idle
    always_ff @(posedge i_sysclk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            qtr_cnt <= 7'd1;
            qtr     <= 2'd0;
        end else if (state == ST_IDLE) begin
            qtr_cnt <= 7'd1;
            qtr     <= 2'd0;
        end else if (tick) begin
            qtr_cnt <= 7'd1;
            qtr     <= qtr + 2'd1;
        end else begin
            qtr_cnt <= qtr_cnt + 7'd1;
        end
    end

    // tx bits shift out msb first, bus level shifts in behind them
    always_ff @(posedge i_sysclk) begin
        if (start_go) begin
            shift_r <= i_cmd.tx_data;
        end else if ((state == ST_BIT) && tick && (qtr == 2'd2)) begin
            shift_r <= {shift_r[6:0], i_sda};
        end
    end

    always_ff @(posedge i_sysclk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            state     <= ST_IDLE;
            op_r      <= CMD_IDLE;
            bit_cnt   <= 3'd0;
            txak_r    <= 1'b0;
            rx_ack_r  <= 1'b1;
            al_r      <= 1'b0;
            scl_low_r <= 1'b0;
            sda_low_r <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start_go) begin
                        op_r    <= i_cmd.op;
                        txak_r  <= i_cmd.txak;
                        bit_cnt <= 3'd0;
                        al_r    <= 1'b0;
                        case (i_cmd.op)
                            CMD_START, CMD_RESTART: state <= ST_START_A;
                            CMD_STOP:               state <= ST_STOP_A;
                            default:                state <= ST_BIT;
                        endcase
                    end
                end
                ST_START_A: begin
                    if (tick) begin
                        case (qtr)
                            2'd0: sda_low_r <= 1'b0;
                            2'd1: scl_low_r <= 1'b0;
                            2'd3: state     <= ST_START_B;
                            default: ;
                        endcase
                    end
                end
                ST_START_B: begin
                    if (tick) begin
                        case (qtr)
                            2'd0: sda_low_r <= 1'b1; // start condition
                            2'd2: scl_low_r <= 1'b1;
                            2'd3: state     <= ST_DONE;
                            default: ;
                        endcase
                    end
                end
                ST_BIT: begin
                    if (tick) begin
                        case (qtr)
                            2'd0: sda_low_r <= (op_r == CMD_WRITE) && !shift_r[7];
                            2'd1: scl_low_r <= 1'b0;
                            2'd2: begin
                                // released sda pulled low by another master
                                if ((op_r == CMD_WRITE) && !sda_low_r && i_scl && !i_sda) begin
                                    al_r      <= 1'b1;
                                    scl_low_r <= 1'b0;
                                    sda_low_r <= 1'b0;
                                    state     <= ST_DONE;
                                end
                            end
                            default: begin
                                scl_low_r <= 1'b1;
                                bit_cnt   <= bit_cnt + 3'd1;
                                if (bit_cnt == 3'd7) begin
                                    state <= ST_ACK;
                                end
                            end
                        endcase
                    end
                end
                ST_ACK: begin
                    if (tick) begin
                        case (qtr)
                            2'd0: sda_low_r <= (op_r == CMD_READ) && !txak_r;
                            2'd1: scl_low_r <= 1'b0;
                            2'd2: rx_ack_r  <= i_sda;
                            default: begin
                                scl_low_r <= 1'b1;
                                state     <= ST_DONE;
                            end
                        endcase
                    end
                end
                ST_STOP_A: begin
                    if (tick) begin
                        case (qtr)
                            2'd0: begin
                                scl_low_r <= 1'b1;
                                sda_low_r <= 1'b1;
                            end
                            2'd1: scl_low_r <= 1'b0;
                            2'd3: state     <= ST_STOP_B;
                            default: ;
                        endcase
                    end
                end
                ST_STOP_B: begin
                    if (tick) begin
                        case (qtr)
                            2'd0: sda_low_r <= 1'b0; // stop condition
                            2'd3: state     <= ST_DONE;
                            default: ;
                        endcase
                    end
                end
                ST_DONE: begin
                    if (op_r == CMD_READ) begin
                        sda_low_r <= 1'b0; // drop our ack while scl is low
                    end
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign o_scl_low     = scl_low_r;
    assign o_sda_low     = sda_low_r;
    assign o_busy        = (state != ST_IDLE);
    assign o_rsp.done    = (state == ST_DONE);
    assign o_rsp.op      = op_r;
    assign o_rsp.rx_data = shift_r;
    assign o_rsp.rx_ack  = rx_ack_r;
    assign o_rsp.al      = al_r;

endmodule

// File: verilog/i2c_master_cfg.svh
`ifndef I2C_MASTER_CFG_SVH
`define I2C_MASTER_CFG_SVH

// register index, taken from host address bits 4:2
`define I2C_ADDR_ADR 3'd0
`define I2C_ADDR_FDR 3'd1
`define I2C_ADDR_CR  3'd2
`define I2C_ADDR_SR  3'd3
`define I2C_ADDR_DR  3'd4

// control register bits
`define I2C_CR_MEN  7
`define I2C_CR_MIEN 6
`define I2C_CR_MSTA 5
`define I2C_CR_MTX  4
`define I2C_CR_TXAK 3
`define I2C_CR_RSTA 2

// status register bits
`define I2C_SR_MCF  7
`define I2C_SR_MBB  5
`define I2C_SR_MAL  4
`define I2C_SR_MIF  1
`define I2C_SR_RXAK 0

`define I2C_SR_RESET 8'h81
`define I2C_CR_RESET 8'h00

// system clocks per quarter of an SCL period, 7 bits wide
`define I2C_QTR_CLKS(fdr) ({1'b0, fdr[5:0]} + 7'd1)

`endif

// File: verilog/i2c_master_pkg.sv
package i2c_master_pkg;

    // byte-level bus operations
    typedef enum logic [2:0] {
        CMD_IDLE    = 3'd0,
        CMD_START   = 3'd1,
        CMD_STOP    = 3'd2,
        CMD_RESTART = 3'd3,
        CMD_WRITE   = 3'd4,
        CMD_READ    = 3'd5
    } i2c_cmd_e;

    // each state except idle and done spans four quarter periods
    typedef enum logic [3:0] {
        ST_IDLE    = 4'd0,
        ST_START_A = 4'd1, // release sda, then scl
        ST_START_B = 4'd2, // sda low under high scl, then scl low
        ST_BIT     = 4'd3,
        ST_ACK     = 4'd4,
        ST_STOP_A  = 4'd5, // sda low, then scl high
        ST_STOP_B  = 4'd6, // sda rises under high scl
        ST_DONE    = 4'd7
    } i2c_bit_state_e;

    typedef struct packed {
        logic       go;      // one-cycle strobe
        i2c_cmd_e   op;
        logic [7:0] tx_data;
        logic       txak;    // 1 answers a read with nak
    } i2c_cmd_t;

    typedef struct packed {
        logic       done;    // one-cycle strobe
        i2c_cmd_e   op;      // finished operation
        logic [7:0] rx_data;
        logic       rx_ack;  // 1 is nak
        logic       al;      // arbitration lost
    } i2c_rsp_t;

endpackage

// File: verilog/i2c_master_top.sv
module i2c_master_top (
    input  logic       i_sysclk,
    input  logic       i_reset_n,
    input  logic       i_wr_ena,
    input  logic [4:0] i_wr_addr,
    input  logic [7:0] i_wr_data,
    input  logic       i_rd_ena,
    input  logic [4:0] i_rd_addr,
    output logic [7:0] o_rd_data,
    output logic       o_read_ready,
    output logic       o_write_ready,
    output logic       o_interrupt,
    input  logic       i_scl,
    input  logic       i_sda,
    output logic       o_scl_low,
    output logic       o_sda_low
);
    import i2c_master_pkg::*;

    i2c_cmd_t   cmd;
    i2c_rsp_t   rsp;
    logic [7:0] sr;
    logic [7:0] cr;
    logic [7:0] fdr;
    logic [7:0] regs_rd;
    logic       busy;

    i2c_reg_decode u_reg_decode (
        .i_sysclk  (i_sysclk),
        .i_reset_n (i_reset_n),
        .i_wr_ena  (i_wr_ena),
        .i_wr_addr (i_wr_addr),
        .i_wr_data (i_wr_data),
        .i_rd_ena  (i_rd_ena),
        .i_rd_addr (i_rd_addr),
        .i_sr      (sr),
        .i_busy    (busy),
        .i_rsp     (rsp),
        .o_cmd     (cmd),
        .o_cr      (cr),
        .o_regs_rd (regs_rd),
        .o_fdr     (fdr)
    );

    i2c_byte_engine u_byte_engine (
        .i_sysclk  (i_sysclk),
        .i_reset_n (i_reset_n),
        .i_cmd     (cmd),
        .i_fdr     (fdr),
        .i_scl     (i_scl),
        .i_sda     (i_sda),
        .o_scl_low (o_scl_low),
        .o_sda_low (o_sda_low),
        .o_busy    (busy),
        .o_rsp     (rsp)
    );

    i2c_status_result u_status_result (
        .i_sysclk      (i_sysclk),
        .i_reset_n     (i_reset_n),
        .i_rsp         (rsp),
        .i_cmd         (cmd),
        .i_wr_ena      (i_wr_ena),
        .i_wr_addr     (i_wr_addr),
        .i_wr_data     (i_wr_data),
        .i_rd_ena      (i_rd_ena),
        .i_rd_addr     (i_rd_addr),
        .i_regs_rd     (regs_rd),
        .i_cr          (cr),
        .o_sr          (sr),
        .o_rd_data     (o_rd_data),
        .o_read_ready  (o_read_ready),
        .o_write_ready (o_write_ready),
        .o_interrupt   (o_interrupt)
    );

endmodule

// File: verilog/i2c_reg_decode.sv
`include "i2c_master_cfg.svh"

module i2c_reg_decode (
    input  logic                     i_sysclk,
    input  logic                     i_reset_n,
    input  logic                     i_wr_ena,
    input  logic [4:0]               i_wr_addr,
    input  logic [7:0]               i_wr_data,
    input  logic                     i_rd_ena,
    input  logic [4:0]               i_rd_addr,
    input  logic [7:0]               i_sr,
    input  logic                     i_busy,
    input  i2c_master_pkg::i2c_rsp_t i_rsp,
    output i2c_master_pkg::i2c_cmd_t o_cmd,
    output logic [7:0]               o_cr,
    output logic [7:0]               o_regs_rd,
    output logic [7:0]               o_fdr
);
    import i2c_master_pkg::*;

    logic [7:0] adr_r;
    logic [7:0] fdr_r;
    logic [7:0] cr_r;
    logic [7:0] dr_r;
    logic [2:0] wr_idx;
    logic [2:0] rd_idx;
    logic       cr_wr;
    logic       dr_wr;
    logic       dr_rd;
    logic       req_valid;
    i2c_cmd_e   req_op;
    logic       issue;
    logic       go_r;
    i2c_cmd_e   op_r;

    assign wr_idx = i_wr_addr[4:2];
    assign rd_idx = i_rd_addr[4:2];
    assign cr_wr  = i_wr_ena && (wr_idx == `I2C_ADDR_CR);
    assign dr_wr  = i_wr_ena && (wr_idx == `I2C_ADDR_DR);
    assign dr_rd  = i_rd_ena && (rd_idx == `I2C_ADDR_DR);

    always_comb begin
        req_valid = 1'b0;
        req_op    = CMD_IDLE;
        if (cr_wr && i_wr_data[`I2C_CR_MEN] &&
            (i_wr_data[`I2C_CR_MSTA] != cr_r[`I2C_CR_MSTA])) begin
            req_valid = 1'b1;
            req_op    = i_wr_data[`I2C_CR_MSTA] ? CMD_START : CMD_STOP;
        end else if (cr_wr && i_wr_data[`I2C_CR_MEN] && i_wr_data[`I2C_CR_RSTA]) begin
            req_valid = 1'b1;
            req_op    = CMD_RESTART;
        end else if (dr_wr && cr_r[`I2C_CR_MEN] && cr_r[`I2C_CR_MTX]) begin
            req_valid = 1'b1;
            req_op    = CMD_WRITE;
        end else if (dr_rd && cr_r[`I2C_CR_MEN] && !cr_r[`I2C_CR_MTX] &&
                     i_sr[`I2C_SR_MBB] && i_sr[`I2C_SR_MIF]) begin
            req_valid = 1'b1; // dummy dr read kicks off the next byte
            req_op    = CMD_READ;
        end
    end

    // commands arriving while the engine runs are dropped
    assign issue = req_valid && !i_busy && !go_r;

    always_ff @(posedge i_sysclk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            adr_r <= 8'h00;
            fdr_r <= 8'h00;
            cr_r  <= `I2C_CR_RESET;
            dr_r  <= 8'h00;
            go_r  <= 1'b0;
            op_r  <= CMD_IDLE;
        end else begin
            go_r <= issue;
            if (issue) begin
                op_r <= req_op;
            end
            if (i_wr_ena && (wr_idx == `I2C_ADDR_ADR)) begin
                adr_r <= i_wr_data;
            end
            if (i_wr_ena && (wr_idx == `I2C_ADDR_FDR)) begin
                fdr_r <= i_wr_data;
            end
            if (cr_wr) begin
                cr_r                <= i_wr_data;
                cr_r[`I2C_CR_RSTA]  <= 1'b0; // restart bit self-clears
            end
            if (i_rsp.done && (i_rsp.op == CMD_READ)) begin
                dr_r <= i_rsp.rx_data;
            end
            if (dr_wr) begin
                dr_r <= i_wr_data;
            end
        end
    end

    always_comb begin
        case (rd_idx)
            `I2C_ADDR_ADR: o_regs_rd = adr_r;
            `I2C_ADDR_FDR: o_regs_rd = fdr_r;
            `I2C_ADDR_CR:  o_regs_rd = cr_r;
            `I2C_ADDR_DR:  o_regs_rd = dr_r;
            default:       o_regs_rd = 8'h00; // sr comes from the status stage
        endcase
    end

    assign o_cmd.go      = go_r;
    assign o_cmd.op      = op_r;
    assign o_cmd.tx_data = dr_r;
    assign o_cmd.txak    = cr_r[`I2C_CR_TXAK];
    assign o_cr          = cr_r;
    assign o_fdr         = fdr_r;

endmodule

// File: verilog/i2c_status_result.sv
`include "i2c_master_cfg.svh"

module i2c_status_result (
    input  logic                     i_sysclk,
    input  logic                     i_reset_n,
    input  i2c_master_pkg::i2c_rsp_t i_rsp,
    input  i2c_master_pkg::i2c_cmd_t i_cmd,
    input  logic                     i_wr_ena,
    input  logic [4:0]               i_wr_addr,
    input  logic [7:0]               i_wr_data,
    input  logic                     i_rd_ena,
    input  logic [4:0]               i_rd_addr,
    input  logic [7:0]               i_regs_rd,
    input  logic [7:0]               i_cr,
    output logic [7:0]               o_sr,
    output logic [7:0]               o_rd_data,
    output logic                     o_read_ready,
    output logic                     o_write_ready,
    output logic                     o_interrupt
);
    import i2c_master_pkg::*;

    logic [7:0] sr_r;
    logic [7:0] rd_data_r;
    logic       wr_ready_r;
    logic       sr_wr;

    assign sr_wr = i_wr_ena && (i_wr_addr[4:2] == `I2C_ADDR_SR);

    always_ff @(posedge i_sysclk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            sr_r       <= `I2C_SR_RESET;
            rd_data_r  <= 8'h00;
            wr_ready_r <= 1'b1;
        end else begin
            // host clears mal and mif by writing zeros
            if (sr_wr && !i_wr_data[`I2C_SR_MAL]) begin
                sr_r[`I2C_SR_MAL] <= 1'b0;
            end
            if (sr_wr && !i_wr_data[`I2C_SR_MIF]) begin
                sr_r[`I2C_SR_MIF] <= 1'b0;
            end
            if (i_cmd.go) begin
                sr_r[`I2C_SR_MCF] <= 1'b0;
                sr_r[`I2C_SR_MIF] <= 1'b0;
                wr_ready_r        <= 1'b0;
            end
            if (i_rsp.done) begin
                sr_r[`I2C_SR_MCF] <= 1'b1;
                sr_r[`I2C_SR_MIF] <= 1'b1;
                wr_ready_r        <= 1'b1;
                case (i_rsp.op)
                    CMD_START, CMD_RESTART: sr_r[`I2C_SR_MBB]  <= 1'b1;
                    CMD_STOP:               sr_r[`I2C_SR_MBB]  <= 1'b0;
                    CMD_WRITE, CMD_READ:    sr_r[`I2C_SR_RXAK] <= i_rsp.rx_ack;
                    default: ;
                endcase
                if (i_rsp.al) begin
                    sr_r[`I2C_SR_MAL] <= 1'b1;
                    sr_r[`I2C_SR_MBB] <= 1'b0; // bus given up
                end
            end
            if (i_rd_ena) begin
                rd_data_r <= (i_rd_addr[4:2] == `I2C_ADDR_SR) ? sr_r : i_regs_rd;
            end
        end
    end

    assign o_sr          = sr_r;
    assign o_rd_data     = rd_data_r;
    assign o_read_ready  = 1'b1; // every read answered next clock
    assign o_write_ready = wr_ready_r;
    assign o_interrupt   = sr_r[`I2C_SR_MIF] & i_cr[`I2C_CR_MIEN];

endmodule
